// ==== build.f ====
source/sat_mem_pkg.sv
source/table_port_if.sv
source/axi_write_ctrl.sv
source/axi_read_ctrl.sv
source/table_bank.sv
source/sat_mem_ctrl_top.sv
verification/tb_sat_mem_ctrl.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f build.f --top-module tb_sat_mem_ctrl -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
exit 0

// ==== source/axi_read_ctrl.sv ====
`timescale 1ns/1ns

module axi_read_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  sat_mem_pkg::axi_id_t    arid_i,
    input  sat_mem_pkg::axi_addr_t  araddr_i,
    input  sat_mem_pkg::axi_len_t   arlen_i,
    input  sat_mem_pkg::axi_size_t  arsize_i,
    input  sat_mem_pkg::axi_burst_t arburst_i,
    input  logic                    arvalid_i,
    output logic                    arready_o,
    output sat_mem_pkg::axi_id_t    rid_o,
    output sat_mem_pkg::axi_data_t  rdata_o,
    output sat_mem_pkg::axi_resp_t  rresp_o,
    output logic                    rlast_o,
    output logic                    rvalid_o,
    input  logic                    rready_i,
    table_port_if.ctrl              rd_port
);

    typedef enum logic [1:0] {R_IDLE, R_REQ, R_WAIT, R_DATA} rd_state_t;

    rd_state_t               state_q;
    sat_mem_pkg::axi_id_t    id_q;
    sat_mem_pkg::axi_addr_t  addr_q;
    sat_mem_pkg::axi_len_t   len_q;
    sat_mem_pkg::axi_size_t  size_q;
    sat_mem_pkg::axi_burst_t burst_q;
    sat_mem_pkg::axi_len_t   beat_q;
    logic                    burst_bad;
    logic                    beat_err;
    logic                    ar_fire;
    logic                    r_fire;

    assign ar_fire   = arvalid_i && arready_o;
    assign r_fire    = rvalid_o && rready_i;
    assign burst_bad = !sat_mem_pkg::burst_legal(len_q, size_q, burst_q);
    assign beat_err  = burst_bad || rd_port.err;

    // One beat in flight, so the request comes straight from the state
    assign rd_port.req   = (state_q == R_REQ);
    assign rd_port.addr  = addr_q + (sat_mem_pkg::axi_addr_t'(beat_q) << 2);
    assign rd_port.wdata = '0;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state_q   <= R_IDLE;
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            rlast_o   <= 1'b0;
            beat_q    <= '0;
        end else begin
            case (state_q)
                R_IDLE: begin
                    arready_o <= !ar_fire;
                    if (ar_fire) begin
                        state_q <= R_REQ;
                        beat_q  <= '0;
                    end
                end
                R_REQ: state_q <= R_WAIT;
                R_WAIT: begin
                    rvalid_o <= 1'b1;
                    rlast_o  <= (beat_q == len_q);
                    state_q  <= R_DATA;
                end
                R_DATA: begin
                    if (r_fire) begin
                        rvalid_o <= 1'b0;
                        rlast_o  <= 1'b0;
                        beat_q   <= beat_q + 1'b1;
                        if (rlast_o) begin
                            arready_o <= 1'b1;
                            state_q   <= R_IDLE;
                        end else begin
                            state_q <= R_REQ;
                        end
                    end
                end
                default: state_q <= R_IDLE;
            endcase
        end
    end

    // Burst fields and the R channel payload
    always_ff @(posedge clk_i) begin
        if (ar_fire) begin
            id_q    <= arid_i;
            addr_q  <= araddr_i;
            len_q   <= arlen_i;
            size_q  <= arsize_i;
            burst_q <= arburst_i;
        end
        if (state_q == R_WAIT) begin
            rid_o   <= id_q;
            rdata_o <= beat_err ? '0 : rd_port.rdata;
            rresp_o <= beat_err ? sat_mem_pkg::RESP_SLVERR : sat_mem_pkg::RESP_OKAY;
        end
    end

    r_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
        rvalid_o && !rready_i |=> $stable(rdata_o) && $stable(rresp_o) && $stable(rlast_o));

endmodule

// ==== source/axi_write_ctrl.sv ====
`timescale 1ns/1ns

module axi_write_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  sat_mem_pkg::axi_id_t    awid_i,
    input  sat_mem_pkg::axi_addr_t  awaddr_i,
    input  sat_mem_pkg::axi_len_t   awlen_i,
    input  sat_mem_pkg::axi_size_t  awsize_i,
    input  sat_mem_pkg::axi_burst_t awburst_i,
    input  logic                    awvalid_i,
    output logic                    awready_o,
    input  sat_mem_pkg::axi_data_t  wdata_i,
    input  logic                    wlast_i,
    input  logic                    wvalid_i,
    output logic                    wready_o,
    output sat_mem_pkg::axi_id_t    bid_o,
    output sat_mem_pkg::axi_resp_t  bresp_o,
    output logic                    bvalid_o,
    input  logic                    bready_i,
    table_port_if.ctrl              wr_port
);

    // W_REQ and W_CHECK cover the bank round trip of the last beat
    typedef enum logic [2:0] {W_IDLE, W_DATA, W_REQ, W_CHECK, W_RESP} wr_state_t;

    wr_state_t               state_q;
    sat_mem_pkg::axi_id_t    id_q;
    sat_mem_pkg::axi_addr_t  addr_q;
    sat_mem_pkg::axi_len_t   len_q;
    sat_mem_pkg::axi_size_t  size_q;
    sat_mem_pkg::axi_burst_t burst_q;
    sat_mem_pkg::axi_len_t   beat_q;
    sat_mem_pkg::axi_resp_t  resp_q;
    sat_mem_pkg::axi_resp_t  resp_next;
    logic                    check_q;
    logic                    burst_bad;
    logic                    aw_fire;
    logic                    w_fire;
    logic                    b_fire;

    assign aw_fire   = awvalid_i && awready_o;
    assign w_fire    = wvalid_i && wready_o;
    assign b_fire    = bvalid_o && bready_i;
    assign burst_bad = !sat_mem_pkg::burst_legal(len_q, size_q, burst_q);

    // Bank err is valid the cycle after a req
    assign resp_next = (check_q && wr_port.err) ? sat_mem_pkg::RESP_SLVERR : resp_q;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state_q     <= W_IDLE;
            awready_o   <= 1'b0;
            wready_o    <= 1'b0;
            bvalid_o    <= 1'b0;
            wr_port.req <= 1'b0;
            check_q     <= 1'b0;
            beat_q      <= '0;
            resp_q      <= sat_mem_pkg::RESP_OKAY;
        end else begin
            wr_port.req <= w_fire && !burst_bad;
            check_q     <= wr_port.req;
            resp_q      <= resp_next;
            case (state_q)
                W_IDLE: begin
                    awready_o <= !aw_fire;
                    if (aw_fire) begin
                        state_q  <= W_DATA;
                        wready_o <= 1'b1;
                        beat_q   <= '0;
                        resp_q   <= sat_mem_pkg::RESP_OKAY;
                    end
                end
                W_DATA: begin
                    if (burst_bad) begin
                        resp_q <= sat_mem_pkg::RESP_SLVERR;
                    end
                    if (w_fire) begin
                        beat_q <= beat_q + 1'b1;
                        if (wlast_i) begin
                            wready_o <= 1'b0;
                            state_q  <= W_REQ;
                        end
                    end
                end
                W_REQ: state_q <= W_CHECK;
                W_CHECK: begin
                    bvalid_o <= 1'b1;
                    state_q  <= W_RESP;
                end
                W_RESP: begin
                    if (b_fire) begin
                        bvalid_o  <= 1'b0;
                        awready_o <= 1'b1;
                        state_q   <= W_IDLE;
                    end
                end
                default: state_q <= W_IDLE;
            endcase
        end
    end

    // Burst fields, beat payload and the B channel payload
    always_ff @(posedge clk_i) begin
        if (aw_fire) begin
            id_q    <= awid_i;
            addr_q  <= awaddr_i;
            len_q   <= awlen_i;
            size_q  <= awsize_i;
            burst_q <= awburst_i;
        end
        if (w_fire) begin
            wr_port.addr  <= addr_q + (sat_mem_pkg::axi_addr_t'(beat_q) << 2);
            wr_port.wdata <= wdata_i;
        end
        if (state_q == W_CHECK) begin
            bid_o   <= id_q;
            bresp_o <= resp_next;
        end
    end

    bvalid_held_a: assert property (@(posedge clk_i) disable iff (rst_i)
        bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o) && $stable(bid_o));

endmodule

// ==== source/sat_mem_ctrl_top.sv ====
`timescale 1ns/1ns

module sat_mem_ctrl_top (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  sat_mem_pkg::axi_id_t    awid_i,
    input  sat_mem_pkg::axi_addr_t  awaddr_i,
    input  sat_mem_pkg::axi_len_t   awlen_i,
    input  sat_mem_pkg::axi_size_t  awsize_i,
    input  sat_mem_pkg::axi_burst_t awburst_i,
    input  logic                    awvalid_i,
    output logic                    awready_o,
    input  sat_mem_pkg::axi_data_t  wdata_i,
    input  logic                    wlast_i,
    input  logic                    wvalid_i,
    output logic                    wready_o,
    output sat_mem_pkg::axi_id_t    bid_o,
    output sat_mem_pkg::axi_resp_t  bresp_o,
    output logic                    bvalid_o,
    input  logic                    bready_i,
    input  sat_mem_pkg::axi_id_t    arid_i,
    input  sat_mem_pkg::axi_addr_t  araddr_i,
    input  sat_mem_pkg::axi_len_t   arlen_i,
    input  sat_mem_pkg::axi_size_t  arsize_i,
    input  sat_mem_pkg::axi_burst_t arburst_i,
    input  logic                    arvalid_i,
    output logic                    arready_o,
    output sat_mem_pkg::axi_id_t    rid_o,
    output sat_mem_pkg::axi_data_t  rdata_o,
    output sat_mem_pkg::axi_resp_t  rresp_o,
    output logic                    rlast_o,
    output logic                    rvalid_o,
    input  logic                    rready_i
);

    table_port_if wr_port ();
    table_port_if rd_port ();

    axi_write_ctrl i_write_ctrl (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .awid_i    (awid_i),
        .awaddr_i  (awaddr_i),
        .awlen_i   (awlen_i),
        .awsize_i  (awsize_i),
        .awburst_i (awburst_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .wdata_i   (wdata_i),
        .wlast_i   (wlast_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .bid_o     (bid_o),
        .bresp_o   (bresp_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .wr_port   (wr_port)
    );

    axi_read_ctrl i_read_ctrl (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .arid_i    (arid_i),
        .araddr_i  (araddr_i),
        .arlen_i   (arlen_i),
        .arsize_i  (arsize_i),
        .arburst_i (arburst_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .rid_o     (rid_o),
        .rdata_o   (rdata_o),
        .rresp_o   (rresp_o),
        .rlast_o   (rlast_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i),
        .rd_port   (rd_port)
    );

    table_bank i_table_bank (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .wr_port (wr_port),
        .rd_port (rd_port)
    );

endmodule

// ==== source/sat_mem_pkg.sv ====
package sat_mem_pkg;

    // AXI channel fields
    typedef logic [3:0]  axi_id_t;
    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [7:0]  axi_len_t;
    typedef logic [2:0]  axi_size_t;
    typedef logic [1:0]  axi_burst_t;
    typedef logic [1:0]  axi_resp_t;

    // ATT entry holds an 11-bit field above a 20-bit field
    typedef logic [30:0] att_entry_t;

    // Entry index inside one region
    typedef logic [5:0]  table_index_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // Only INCR bursts of 4-byte beats are served
    localparam axi_burst_t BURST_INCR    = 2'b01;
    localparam axi_size_t  BEAT_SIZE     = 3'd2;
    localparam int         MAX_BURST_LEN = 16;

    // Address map
    localparam axi_addr_t ATT_BASE     = 32'h0000_0000;
    localparam axi_addr_t VARCL1_BASE  = 32'h0000_1000;
    localparam axi_addr_t VARCL2_BASE  = 32'h0000_2000;
    localparam axi_addr_t REGION_BYTES = 32'h0000_0100;
    localparam int        TABLE_DEPTH  = 64;

    // Legality of a burst from its address channel fields
    function automatic logic burst_legal(
        axi_len_t   len,
        axi_size_t  size,
        axi_burst_t burst
    );
        return (burst == BURST_INCR) && (size == BEAT_SIZE) && (int'(len) < MAX_BURST_LEN);
    endfunction

endpackage

// ==== source/table_bank.sv ====
`timescale 1ns/1ns

module table_bank (
    input  logic       clk_i,
    input  logic       rst_i,
    table_port_if.bank wr_port,
    table_port_if.bank rd_port
);

    sat_mem_pkg::att_entry_t    att_mem [sat_mem_pkg::TABLE_DEPTH];
    logic [sat_mem_pkg::TABLE_DEPTH-1:0] varcl1_mem;
    logic [sat_mem_pkg::TABLE_DEPTH-1:0] varcl2_mem;
    logic                       wr_att, wr_cl1, wr_cl2;
    logic                       rd_att, rd_cl1, rd_cl2;
    sat_mem_pkg::table_index_t  wr_idx;
    sat_mem_pkg::table_index_t  rd_idx;
    sat_mem_pkg::axi_data_t     wr_value;
    sat_mem_pkg::axi_data_t     rd_value;

    function automatic logic in_region(
        sat_mem_pkg::axi_addr_t addr,
        sat_mem_pkg::axi_addr_t base
    );
        return (addr >= base) && (addr < base + sat_mem_pkg::REGION_BYTES);
    endfunction

    // Word index of the address within its region
    function automatic sat_mem_pkg::table_index_t entry_index(
        sat_mem_pkg::axi_addr_t addr,
        sat_mem_pkg::axi_addr_t base
    );
        sat_mem_pkg::axi_addr_t offset;
        offset = addr - base;
        return sat_mem_pkg::table_index_t'(offset >> 2);
    endfunction

    assign wr_att = in_region(wr_port.addr, sat_mem_pkg::ATT_BASE);
    assign wr_cl1 = in_region(wr_port.addr, sat_mem_pkg::VARCL1_BASE);
    assign wr_cl2 = in_region(wr_port.addr, sat_mem_pkg::VARCL2_BASE);
    assign rd_att = in_region(rd_port.addr, sat_mem_pkg::ATT_BASE);
    assign rd_cl1 = in_region(rd_port.addr, sat_mem_pkg::VARCL1_BASE);
    assign rd_cl2 = in_region(rd_port.addr, sat_mem_pkg::VARCL2_BASE);

    // Regions are the same size, so any base gives the same index
    assign wr_idx = entry_index(wr_port.addr, wr_port.addr & ~(sat_mem_pkg::REGION_BYTES - 1));
    assign rd_idx = entry_index(rd_port.addr, rd_port.addr & ~(sat_mem_pkg::REGION_BYTES - 1));

    // Value as stored, zero-extended
    assign wr_value = wr_att ? sat_mem_pkg::axi_data_t'(sat_mem_pkg::att_entry_t'(wr_port.wdata))
                             : sat_mem_pkg::axi_data_t'(wr_port.wdata[0]);

    always_comb begin
        rd_value = '0;
        if (rd_att) begin
            rd_value = sat_mem_pkg::axi_data_t'(att_mem[rd_idx]);
        end else if (rd_cl1) begin
            rd_value = sat_mem_pkg::axi_data_t'(varcl1_mem[rd_idx]);
        end else if (rd_cl2) begin
            rd_value = sat_mem_pkg::axi_data_t'(varcl2_mem[rd_idx]);
        end
        // Write first, read second
        if (wr_port.req && (wr_idx == rd_idx) &&
            ((wr_att && rd_att) || (wr_cl1 && rd_cl1) || (wr_cl2 && rd_cl2))) begin
            rd_value = wr_value;
        end
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            for (int i = 0; i < sat_mem_pkg::TABLE_DEPTH; i++) begin
                att_mem[i] <= '0;
            end
            varcl1_mem <= '0;
            varcl2_mem <= '0;
        end else if (wr_port.req) begin
            if (wr_att) begin
                att_mem[wr_idx] <= sat_mem_pkg::att_entry_t'(wr_port.wdata);
            end else if (wr_cl1) begin
                varcl1_mem[wr_idx] <= wr_port.wdata[0];
            end else if (wr_cl2) begin
                varcl2_mem[wr_idx] <= wr_port.wdata[0];
            end
        end
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            wr_port.err   <= 1'b0;
            rd_port.err   <= 1'b0;
            rd_port.rdata <= '0;
        end else begin
            if (wr_port.req) begin
                wr_port.err <= !(wr_att || wr_cl1 || wr_cl2);
            end
            if (rd_port.req) begin
                rd_port.err   <= !(rd_att || rd_cl1 || rd_cl2);
                rd_port.rdata <= rd_value;
            end
        end
    end

    // Write port carries no read data
    assign wr_port.rdata = '0;

    rd_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
        !rd_port.req |=> $stable(rd_port.err) && $stable(rd_port.rdata));

    wr_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
        !wr_port.req |=> $stable(wr_port.err));

endmodule

// ==== source/table_port_if.sv ====
`timescale 1ns/1ns

// One access per req, answered a cycle later by the bank
interface table_port_if;

    logic                   req;
    sat_mem_pkg::axi_addr_t addr;
    sat_mem_pkg::axi_data_t wdata;
    sat_mem_pkg::axi_data_t rdata;
    logic                   err;

    modport ctrl (
        output req,
        output addr,
        output wdata,
        input  rdata,
        input  err
    );

    modport bank (
        input  req,
        input  addr,
        input  wdata,
        output rdata,
        output err
    );

endinterface

// ==== verification/tb_sat_mem_ctrl.sv ====
`timescale 1ns/1ns

module tb_sat_mem_ctrl;

    localparam int NUM_TESTS       = 6;
    localparam int LONGEST_BURST   = sat_mem_pkg::MAX_BURST_LEN + 1;
    localparam int WATCHDOG_CYCLES = 8 + NUM_TESTS * LONGEST_BURST * 40;

    logic                    clk_i;
    logic                    rst_i;
    sat_mem_pkg::axi_id_t    awid_i;
    sat_mem_pkg::axi_addr_t  awaddr_i;
    sat_mem_pkg::axi_len_t   awlen_i;
    sat_mem_pkg::axi_size_t  awsize_i;
    sat_mem_pkg::axi_burst_t awburst_i;
    logic                    awvalid_i;
    logic                    awready_o;
    sat_mem_pkg::axi_data_t  wdata_i;
    logic                    wlast_i;
    logic                    wvalid_i;
    logic                    wready_o;
    sat_mem_pkg::axi_id_t    bid_o;
    sat_mem_pkg::axi_resp_t  bresp_o;
    logic                    bvalid_o;
    logic                    bready_i;
    sat_mem_pkg::axi_id_t    arid_i;
    sat_mem_pkg::axi_addr_t  araddr_i;
    sat_mem_pkg::axi_len_t   arlen_i;
    sat_mem_pkg::axi_size_t  arsize_i;
    sat_mem_pkg::axi_burst_t arburst_i;
    logic                    arvalid_i;
    logic                    arready_o;
    sat_mem_pkg::axi_id_t    rid_o;
    sat_mem_pkg::axi_data_t  rdata_o;
    sat_mem_pkg::axi_resp_t  rresp_o;
    logic                    rlast_o;
    logic                    rvalid_o;
    logic                    rready_i;

    logic [31:0] rng_state = 32'hc0df;
    int          max_delay;
    int          error_count;
    int          check_count;
    int          test_count;
    int          test_start_errors;

    // Model of the three tables, values as stored
    sat_mem_pkg::axi_data_t model_mem [3][sat_mem_pkg::TABLE_DEPTH];

    // Expected responses in the order they must arrive
    sat_mem_pkg::axi_data_t exp_rdata_q [$];
    sat_mem_pkg::axi_resp_t exp_rresp_q [$];
    sat_mem_pkg::axi_id_t   exp_rid_q [$];
    logic                   exp_rlast_q [$];
    sat_mem_pkg::axi_resp_t exp_bresp_q [$];
    sat_mem_pkg::axi_id_t   exp_bid_q [$];

    sat_mem_ctrl_top i_dut (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .awid_i    (awid_i),
        .awaddr_i  (awaddr_i),
        .awlen_i   (awlen_i),
        .awsize_i  (awsize_i),
        .awburst_i (awburst_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .wdata_i   (wdata_i),
        .wlast_i   (wlast_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .bid_o     (bid_o),
        .bresp_o   (bresp_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .arid_i    (arid_i),
        .araddr_i  (araddr_i),
        .arlen_i   (arlen_i),
        .arsize_i  (arsize_i),
        .arburst_i (arburst_i),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .rid_o     (rid_o),
        .rdata_o   (rdata_o),
        .rresp_o   (rresp_o),
        .rlast_o   (rlast_o),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic int unsigned next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic sat_mem_pkg::axi_addr_t region_base(int r);
        case (r)
            0:       return sat_mem_pkg::ATT_BASE;
            1:       return sat_mem_pkg::VARCL1_BASE;
            default: return sat_mem_pkg::VARCL2_BASE;
        endcase
    endfunction

    // Region number of a byte address, -1 when it hits no region
    function automatic int region_of(sat_mem_pkg::axi_addr_t addr);
        for (int r = 0; r < 3; r++) begin
            if (addr >= region_base(r) && addr - region_base(r) < sat_mem_pkg::REGION_BYTES) begin
                return r;
            end
        end
        return -1;
    endfunction

    function automatic int entry_of(sat_mem_pkg::axi_addr_t addr, int r);
        return int'((addr - region_base(r)) >> 2);
    endfunction

    // INCR with 4-byte beats and at most 16 beats
    function automatic logic burst_ok(
        sat_mem_pkg::axi_len_t   len,
        sat_mem_pkg::axi_size_t  size,
        sat_mem_pkg::axi_burst_t burst
    );
        return burst == 2'b01 && size == 3'd2 && len <= 8'd15;
    endfunction

    // ATT keeps 31 bits, a cluster keeps bit 0
    function automatic sat_mem_pkg::axi_data_t stored_value(int r, sat_mem_pkg::axi_data_t d);
        return (r == 0) ? (d & 32'h7fff_ffff) : {31'b0, d[0]};
    endfunction

    function automatic sat_mem_pkg::axi_resp_t expect_read(
        input  sat_mem_pkg::axi_addr_t  addr,
        input  sat_mem_pkg::axi_len_t   len,
        input  sat_mem_pkg::axi_size_t  size,
        input  sat_mem_pkg::axi_burst_t burst,
        input  int                      beat,
        output sat_mem_pkg::axi_data_t  data
    );
        sat_mem_pkg::axi_addr_t beat_addr;
        int                     r;
        beat_addr = addr + sat_mem_pkg::axi_addr_t'(beat * 4);
        data = '0;
        if (!burst_ok(len, size, burst)) begin
            return sat_mem_pkg::RESP_SLVERR;
        end
        r = region_of(beat_addr);
        if (r < 0) begin
            return sat_mem_pkg::RESP_SLVERR;
        end
        data = model_mem[r][entry_of(beat_addr, r)];
        return sat_mem_pkg::RESP_OKAY;
    endfunction

    task automatic check_data(string name, sat_mem_pkg::axi_data_t got,
                              sat_mem_pkg::axi_data_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_resp(string name, sat_mem_pkg::axi_resp_t got,
                              sat_mem_pkg::axi_resp_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_id(string name, sat_mem_pkg::axi_id_t got, sat_mem_pkg::axi_id_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_last(string name, logic got, logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // Every R and B handshake against the next expected response
    always @(posedge clk_i) begin
        if (!rst_i && rvalid_o && rready_i) begin
            if (exp_rdata_q.size() == 0) begin
                error_count++;
                $display("Read beat arrived with no beat expected at %0t", $time);
            end else begin
                check_data("rdata_o", rdata_o, exp_rdata_q.pop_front());
                check_resp("rresp_o", rresp_o, exp_rresp_q.pop_front());
                check_id("rid_o", rid_o, exp_rid_q.pop_front());
                check_last("rlast_o", rlast_o, exp_rlast_q.pop_front());
            end
        end
        if (!rst_i && bvalid_o && bready_i) begin
            if (exp_bresp_q.size() == 0) begin
                error_count++;
                $display("Write response arrived with none expected at %0t", $time);
            end else begin
                check_resp("bresp_o", bresp_o, exp_bresp_q.pop_front());
                check_id("bid_o", bid_o, exp_bid_q.pop_front());
            end
        end
    end

    // Tasks start and end on a falling edge
    task automatic write_burst(sat_mem_pkg::axi_id_t id, sat_mem_pkg::axi_addr_t addr,
                               sat_mem_pkg::axi_len_t len, sat_mem_pkg::axi_size_t size,
                               sat_mem_pkg::axi_burst_t burst);
        sat_mem_pkg::axi_data_t data;
        sat_mem_pkg::axi_addr_t beat_addr;
        sat_mem_pkg::axi_resp_t resp;
        int                     r;
        int                     delay;
        resp = burst_ok(len, size, burst) ? sat_mem_pkg::RESP_OKAY : sat_mem_pkg::RESP_SLVERR;
        awid_i    = id;
        awaddr_i  = addr;
        awlen_i   = len;
        awsize_i  = size;
        awburst_i = burst;
        awvalid_i = 1'b1;
        while (!awready_o) @(negedge clk_i);
        @(negedge clk_i);
        awvalid_i = 1'b0;
        for (int b = 0; b <= int'(len); b++) begin
            data = next_rand();
            beat_addr = addr + sat_mem_pkg::axi_addr_t'(b * 4);
            if (burst_ok(len, size, burst)) begin
                r = region_of(beat_addr);
                if (r < 0) begin
                    resp = sat_mem_pkg::RESP_SLVERR;
                end else begin
                    model_mem[r][entry_of(beat_addr, r)] = stored_value(r, data);
                end
            end
            wdata_i  = data;
            wlast_i  = (b == int'(len));
            wvalid_i = 1'b1;
            while (!wready_o) @(negedge clk_i);
            @(negedge clk_i);
        end
        wvalid_i = 1'b0;
        wlast_i  = 1'b0;
        exp_bresp_q.push_back(resp);
        exp_bid_q.push_back(id);
        delay = int'(next_rand() % (max_delay + 1));
        repeat (delay) @(negedge clk_i);
        bready_i = 1'b1;
        while (!bvalid_o) @(negedge clk_i);
        @(negedge clk_i);
        bready_i = 1'b0;
    endtask

    task automatic read_burst(sat_mem_pkg::axi_id_t id, sat_mem_pkg::axi_addr_t addr,
                              sat_mem_pkg::axi_len_t len, sat_mem_pkg::axi_size_t size,
                              sat_mem_pkg::axi_burst_t burst);
        sat_mem_pkg::axi_data_t data;
        sat_mem_pkg::axi_resp_t resp;
        int                     delay;
        for (int b = 0; b <= int'(len); b++) begin
            resp = expect_read(addr, len, size, burst, b, data);
            exp_rdata_q.push_back(data);
            exp_rresp_q.push_back(resp);
            exp_rid_q.push_back(id);
            exp_rlast_q.push_back(b == int'(len));
        end
        arid_i    = id;
        araddr_i  = addr;
        arlen_i   = len;
        arsize_i  = size;
        arburst_i = burst;
        arvalid_i = 1'b1;
        while (!arready_o) @(negedge clk_i);
        @(negedge clk_i);
        arvalid_i = 1'b0;
        for (int b = 0; b <= int'(len); b++) begin
            delay = int'(next_rand() % (max_delay + 1));
            repeat (delay) @(negedge clk_i);
            rready_i = 1'b1;
            while (!rvalid_o) @(negedge clk_i);
            @(negedge clk_i);
            rready_i = 1'b0;
        end
    endtask

    task automatic start_test();
        test_count++;
        test_start_errors = error_count;
    endtask

    task automatic finish_test(string name);
        if (exp_rdata_q.size() != 0 || exp_bresp_q.size() != 0) begin
            error_count++;
            $display("Responses still outstanding at the end of %s", name);
        end
        $display("Test %0d %s: %0d errors", test_count, name, error_count - test_start_errors);
    endtask

    initial begin
        sat_mem_pkg::axi_len_t len;
        int                    idx;
        int                    att_idx;
        sat_mem_pkg::axi_len_t att_len;
        int                    r;
        awid_i = '0;
        awaddr_i = '0;
        awlen_i = '0;
        awsize_i = '0;
        awburst_i = '0;
        awvalid_i = 1'b0;
        wdata_i = '0;
        wlast_i = 1'b0;
        wvalid_i = 1'b0;
        bready_i = 1'b0;
        arid_i = '0;
        araddr_i = '0;
        arlen_i = '0;
        arsize_i = '0;
        arburst_i = '0;
        arvalid_i = 1'b0;
        rready_i = 1'b0;
        rst_i = 1'b1;
        max_delay = 0;
        error_count = 0;
        check_count = 0;
        test_count = 0;
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < sat_mem_pkg::TABLE_DEPTH; j++) begin
                model_mem[i][j] = '0;
            end
        end
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        start_test();
        check_last("awready_o", awready_o, 1'b0);
        check_last("wready_o", wready_o, 1'b0);
        check_last("bvalid_o", bvalid_o, 1'b0);
        check_last("arready_o", arready_o, 1'b0);
        check_last("rvalid_o", rvalid_o, 1'b0);
        check_last("rlast_o", rlast_o, 1'b0);
        finish_test("reset levels");

        start_test();
        att_len = sat_mem_pkg::axi_len_t'(4 + next_rand() % 12);
        att_idx = int'(next_rand() % (64 - (int'(att_len) + 1)));
        write_burst(4'h3, region_base(0) + sat_mem_pkg::axi_addr_t'(att_idx * 4), att_len, 3'd2,
                    sat_mem_pkg::BURST_INCR);
        read_burst(4'h5, region_base(0) + sat_mem_pkg::axi_addr_t'(att_idx * 4), att_len, 3'd2,
                   sat_mem_pkg::BURST_INCR);
        finish_test("ATT burst");

        // Same index span in both clusters, then the ATT again
        start_test();
        write_burst(4'h1, region_base(1) + sat_mem_pkg::axi_addr_t'(att_idx * 4), att_len, 3'd2,
                    sat_mem_pkg::BURST_INCR);
        write_burst(4'h2, region_base(2) + sat_mem_pkg::axi_addr_t'(att_idx * 4), att_len, 3'd2,
                    sat_mem_pkg::BURST_INCR);
        for (int k = 0; k < 3; k++) begin
            read_burst(sat_mem_pkg::axi_id_t'(8 + k),
                       region_base(k) + sat_mem_pkg::axi_addr_t'(att_idx * 4), att_len, 3'd2,
                       sat_mem_pkg::BURST_INCR);
        end
        finish_test("variable clusters");

        // Eight beats from entry 60, the last four past the ATT
        start_test();
        write_burst(4'h6, region_base(0) + 32'h0f0, 8'd7, 3'd2, sat_mem_pkg::BURST_INCR);
        read_burst(4'h7, region_base(0) + 32'h0f0, 8'd7, 3'd2, sat_mem_pkg::BURST_INCR);
        write_burst(4'h6, region_base(2) + 32'h0f8, 8'd3, 3'd2, sat_mem_pkg::BURST_INCR);
        read_burst(4'h7, region_base(2) + 32'h0f8, 8'd3, 3'd2, sat_mem_pkg::BURST_INCR);
        finish_test("out-of-range beat");

        start_test();
        write_burst(4'ha, region_base(0), 8'd3, 3'd2, 2'b00);
        write_burst(4'hb, region_base(1), 8'd16, 3'd2, sat_mem_pkg::BURST_INCR);
        write_burst(4'hc, region_base(2), 8'd3, 3'd1, sat_mem_pkg::BURST_INCR);
        read_burst(4'ha, region_base(0), 8'd3, 3'd2, 2'b00);
        read_burst(4'hb, region_base(1), 8'd16, 3'd2, sat_mem_pkg::BURST_INCR);
        read_burst(4'hc, region_base(2), 8'd3, 3'd1, sat_mem_pkg::BURST_INCR);
        read_burst(4'hd, region_base(0), 8'd3, 3'd2, sat_mem_pkg::BURST_INCR);
        read_burst(4'hd, region_base(1), 8'd15, 3'd2, sat_mem_pkg::BURST_INCR);
        read_burst(4'hd, region_base(2), 8'd3, 3'd2, sat_mem_pkg::BURST_INCR);
        finish_test("bad burst");

        start_test();
        max_delay = 4;
        repeat (3) begin
            r   = int'(next_rand() % 3);
            len = sat_mem_pkg::axi_len_t'(next_rand() % 16);
            idx = int'(next_rand() % (64 - (int'(len) + 1)));
            write_burst(sat_mem_pkg::axi_id_t'(next_rand()),
                        region_base(r) + sat_mem_pkg::axi_addr_t'(idx * 4), len, 3'd2,
                        sat_mem_pkg::BURST_INCR);
            read_burst(sat_mem_pkg::axi_id_t'(next_rand()),
                       region_base(r) + sat_mem_pkg::axi_addr_t'(idx * 4), len, 3'd2,
                       sat_mem_pkg::BURST_INCR);
        end
        finish_test("back-pressure");

        $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule
